/* source/cart_types_pkg.sv */
`default_nettype none

package cart_types_pkg;

	typedef logic [14:0] cpu_addr_t;    // CPU A14-A0, A15 comes as romsel
	typedef logic [7:0]  cpu_data_t;    // CPU data byte
	typedef logic [13:0] ppu_addr_t;    // PPU A13-A0
	typedef logic [13:0] flash_addr_t;  // Flash/SRAM A26-A13

	typedef logic [12:0] prg_base_t;    // Outer PRG base, A26-A14
	typedef logic [4:0]  prg_mask_t;    // PRG mask, A18-A14
	typedef logic [4:0]  chr_mask_t;    // CHR mask, A17-A13
	typedef logic [5:0]  prg_bank_t;    // Mapped CPU bank, A18-A13
	typedef logic [7:0]  chr_bank_t;    // Mapped PPU bank, A17-A10
	typedef logic [7:0]  bank_reg_t;    // Raw mapper bank register
	typedef logic [1:0]  sram_page_t;   // 8K SRAM page
	typedef logic [1:0]  mirroring_t;   // Nametable mirroring mode
	typedef logic [12:0] irq_count_t;   // #40 IRQ counter

	localparam mirroring_t MIRROR_VERTICAL   = 2'd0;  // A10 from PPU A10
	localparam mirroring_t MIRROR_HORIZONTAL = 2'd1;  // A10 from PPU A11
	localparam mirroring_t MIRROR_SINGLE_A   = 2'd2;  // A10 fixed low
	localparam mirroring_t MIRROR_SINGLE_B   = 2'd3;  // A10 fixed high

	typedef enum logic [4:0] {
		MAP_UXROM = 5'd1,   // #2
		MAP_CNROM = 5'd2,   // #3
		MAP_AXROM = 5'd8,   // #7
		MAP_SMB2J = 5'd18   // #40 with flags 0
	} mapper_e;

endpackage

`default_nettype wire

/* source/cart_bus_pkg.sv */
`default_nettype none

package cart_bus_pkg;

	import cart_types_pkg::*;

	typedef struct packed {
		logic      romsel;    // Low for $8000-$FFFF
		logic      cpu_rw;    // Low on a write cycle
		cpu_addr_t cpu_addr;
		cpu_data_t cpu_data;
	} cpu_bus_t;

	// One accepted write into $8000-$FFFF
	typedef struct packed {
		logic      valid;     // Single-cycle strobe
		cpu_addr_t cpu_addr;
		cpu_data_t cpu_data;
	} rom_write_t;

	typedef struct packed {
		prg_base_t  prg_base;      // $5xx0/$5xx1
		prg_mask_t  prg_mask;      // $5xx2
		chr_mask_t  chr_mask;      // $5xx4
		sram_page_t sram_page;     // $5xx5
		mapper_e    mapper;        // $5xx6 low bits
		logic [2:0] flags;         // $5xx6 high bits
		mirroring_t mirroring;     // $5xx7 or mapper write
		logic       lockout;       // Freezes the window
		logic       prg_write_en;  // Flash writes allowed
		logic       chr_write_en;  // CHR RAM writes allowed
		logic       sram_en;       // SRAM at $6000
	} cart_config_t;

	typedef struct packed {
		logic       valid;    // One-cycle request
		mirroring_t mode;
	} mirror_req_t;

	typedef struct packed {
		bank_reg_t   prg_bank;    // UxROM/AxROM PRG
		bank_reg_t   chr_bank;    // CNROM CHR
		bank_reg_t   smb2j_c000;  // #40 bank at $C000
		mirror_req_t mirror_set;  // AxROM single-screen select
	} bank_state_t;

	typedef struct packed {
		logic start;  // Clear and run
		logic stop;   // Clear, halt, ack
	} irq_ctrl_t;

endpackage

`default_nettype wire

/* source/config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module config_regs
	import cart_types_pkg::*, cart_bus_pkg::*;
(
	input  wire          m2,
	input  wire          ppu_addr_in,  // Async reset, active high
	input  wire cpu_bus_t     cpu_bus,
	input  wire mirror_req_t  mirror_set,
	output cart_config_t cfg,
	output rom_write_t   rom_wr
);

	logic      last_rw;    // cpu_rw on the previous edge
	logic      wr_accept;  // First write after a read
	logic      cfg_hit;    // Write into the $5xxx window
	cpu_data_t wr_data;

	assign wr_data = cpu_bus.cpu_data;
	assign wr_accept = ~cpu_bus.cpu_rw & last_rw;  // RMW dummy write dropped
	assign cfg_hit = wr_accept & cpu_bus.romsel & ~cfg.lockout &
		(cpu_bus.cpu_addr[14:12] == 3'b101);         // $5000-$5FFF

	assign rom_wr.valid = wr_accept & ~cpu_bus.romsel;  // $8000-$FFFF only
	assign rom_wr.cpu_addr = cpu_bus.cpu_addr;
	assign rom_wr.cpu_data = wr_data;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			last_rw <= 1'b1;  // First write after reset goes through
			cfg <= '0;
		end
		else
		begin
			last_rw <= cpu_bus.cpu_rw;
			if (cfg_hit)
			begin
				case (cpu_bus.cpu_addr[2:0])  // Mirrored every 8 bytes
					3'd0: cfg.prg_base[12:8] <= wr_data[4:0];  // A26-A22
					3'd1: cfg.prg_base[7:0] <= wr_data;        // A21-A14
					3'd2: cfg.prg_mask <= wr_data[4:0];
					3'd4: cfg.chr_mask <= wr_data[4:0];
					3'd5: cfg.sram_page <= wr_data[1:0];
					3'd6:
					begin
						cfg.flags <= wr_data[7:5];
						cfg.mapper <= mapper_e'(wr_data[4:0]);  // Unknown codes map nothing
					end
					3'd7:
					begin
						cfg.lockout <= wr_data[7];
						cfg.mirroring <= wr_data[4:3];
						cfg.prg_write_en <= wr_data[2];
						cfg.chr_write_en <= wr_data[1];
						cfg.sram_en <= wr_data[0];
					end
					default: ;  // $5xx3 has no register here
				endcase
			end
			if (mirror_set.valid)
				cfg.mirroring <= mirror_set.mode;  // One edge after the AxROM write
		end
	end

endmodule

`default_nettype wire

/* source/bank_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_regs
	import cart_types_pkg::*, cart_bus_pkg::*;
#(
	parameter int USE_SMB2J = 1  // 0 drops the #40 decode
)
(
	input  wire          m2,
	input  wire          ppu_addr_in,  // Async reset, active high
	input  wire rom_write_t   rom_wr,
	input  wire cart_config_t cfg,
	output bank_state_t  banks,
	output irq_ctrl_t    irq_ctrl
);

	logic      smb2j_on;  // #40 selected and built in
	cpu_data_t wr_data;
	logic      a14;
	logic      a13;

	assign smb2j_on = (USE_SMB2J != 0) && (cfg.mapper == MAP_SMB2J) &&
		(cfg.flags == 3'b000);
	assign wr_data = rom_wr.cpu_data;
	assign a14 = rom_wr.cpu_addr[14];
	assign a13 = rom_wr.cpu_addr[13];

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			banks <= '0;
			irq_ctrl <= '0;
		end
		else
		begin
			banks.mirror_set.valid <= 1'b0;  // Requests last one cycle
			irq_ctrl <= '0;                  // So do timer pulses
			if (rom_wr.valid)
			begin
				case (cfg.mapper)
					MAP_UXROM: banks.prg_bank <= wr_data;  // 16K at $8000
					MAP_CNROM: banks.chr_bank <= wr_data;  // 8K CHR
					MAP_AXROM:
					begin
						banks.prg_bank <= {3'b000, wr_data[4:0]};  // 32K PRG
						banks.mirror_set.valid <= 1'b1;
						banks.mirror_set.mode <= {1'b1, wr_data[4]};  // Single-screen A/B
					end
					MAP_SMB2J:
					begin
						if (smb2j_on)
						begin
							case ({a14, a13})
								2'b00: irq_ctrl.stop <= 1'b1;           // $8000 ack and halt
								2'b01: irq_ctrl.start <= 1'b1;          // $A000 restart
								2'b11: banks.smb2j_c000 <= wr_data;     // $E000 bank at $C000
								default: ;
							endcase
						end
					end
					default: ;  // Writes to ROM ignored
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/irq_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_timer
	import cart_types_pkg::*, cart_bus_pkg::*;
(
	input  wire       m2,
	input  wire       ppu_addr_in,  // Async reset, active high
	input  wire irq_ctrl_t irq_ctrl,
	output logic      irq           // Active low
);

	logic       irq_en;     // Counting enabled
	irq_count_t irq_count;  // Free-running M2 cycle count

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			irq_en <= 1'b0;
			irq_count <= '0;
		end
		else if (irq_ctrl.stop)
		begin
			irq_en <= 1'b0;
			irq_count <= '0;  // Releases irq
		end
		else if (irq_ctrl.start)
		begin
			irq_en <= 1'b1;
			irq_count <= '0;
		end
		else if (irq_en)
			irq_count <= irq_count + 1'b1;
	end

	assign irq = ~irq_count[12];  // Low after 4096 counts

endmodule

`default_nettype wire

/* source/prg_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module prg_mapper
	import cart_types_pkg::*, cart_bus_pkg::*;
#(
	parameter int USE_SMB2J = 1  // 0 drops ROM at $6000
)
(
	input  wire cpu_bus_t     cpu_bus,
	input  wire cart_config_t cfg,
	input  wire bank_state_t  banks,
	output flash_addr_t  cpu_addr_out,
	output logic         flash_we,
	output logic         flash_oe,
	output logic         sram_ce,
	output logic         sram_we,
	output logic         sram_oe
);

	logic       a14;
	logic       a13;
	logic [4:0] map_code;    // Raw mapper code bits
	logic       smb2j_on;
	logic       in_6000;     // $6000-$7FFF
	logic       rom_access;  // Flash selected
	prg_bank_t  mapped;      // A18-A13 before masking
	prg_base_t  rom_hi;      // A26-A14 after base and mask

	assign a14 = cpu_bus.cpu_addr[14];
	assign a13 = cpu_bus.cpu_addr[13];
	assign map_code = cfg.mapper;
	assign smb2j_on = (USE_SMB2J != 0) && (cfg.mapper == MAP_SMB2J) &&
		(cfg.flags == 3'b000);
	assign in_6000 = cpu_bus.romsel & a14 & a13;
	assign rom_access = ~cpu_bus.romsel | (in_6000 & smb2j_on);

	always_comb
	begin
		if (map_code[3] == 1'b0)
			mapped = a14 ? {5'b11111, a13} : {banks.prg_bank[4:0], a13};  // UxROM style, last bank fixed
		else
			mapped = {banks.prg_bank[3:0], a14, a13};  // AxROM style, 32K
		if (smb2j_on)
		begin
			case ({~cpu_bus.romsel, a14, a13})
				3'b011: mapped = 6'd6;                     // $6000
				3'b100: mapped = 6'd4;                     // $8000
				3'b101: mapped = 6'd5;                     // $A000
				3'b110: mapped = banks.smb2j_c000[5:0];  // $C000 switchable
				3'b111: mapped = 6'd7;                     // $E000
				default: ;
			endcase
		end
	end

	assign rom_hi = cfg.prg_base | {8'b0, mapped[5:1] & ~cfg.prg_mask};
	assign cpu_addr_out = rom_access ? {rom_hi, mapped[0]} : {12'b0, cfg.sram_page};

	assign flash_we = cpu_bus.cpu_rw | cpu_bus.romsel | ~cfg.prg_write_en;
	assign flash_oe = ~cpu_bus.cpu_rw | ~rom_access;
	assign sram_ce = ~(in_6000 & cfg.sram_en & ~smb2j_on);  // ROM wins at $6000
	assign sram_we = cpu_bus.cpu_rw;
	assign sram_oe = ~cpu_bus.cpu_rw;

endmodule

`default_nettype wire

/* source/chr_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module chr_mapper
	import cart_types_pkg::*, cart_bus_pkg::*;
(
	input  wire cart_config_t cfg,
	input  wire bank_state_t  banks,
	input  wire          ppu_rd,
	input  wire          ppu_wr,
	input  wire ppu_addr_t    ppu_addr,
	output chr_bank_t    ppu_addr_out,
	output logic         ppu_rd_out,
	output logic         ppu_wr_out,
	output logic         ppu_ciram_a10
);

	logic       smb2j_on;  // #40 has fixed 8K CHR
	logic [4:0] chr_hi;    // A17-A13 before masking

	assign smb2j_on = (cfg.mapper == MAP_SMB2J) && (cfg.flags == 3'b000);
	assign chr_hi = smb2j_on ? 5'b00000 : banks.chr_bank[4:0];
	assign ppu_addr_out = {chr_hi & ~cfg.chr_mask, ppu_addr[12:10]};

	always_comb
	begin
		case (cfg.mirroring)
			MIRROR_VERTICAL:   ppu_ciram_a10 = ppu_addr[10];
			MIRROR_HORIZONTAL: ppu_ciram_a10 = ppu_addr[11];
			MIRROR_SINGLE_A:   ppu_ciram_a10 = 1'b0;
			default:           ppu_ciram_a10 = 1'b1;  // Single-screen B
		endcase
	end

	assign ppu_rd_out = ppu_rd | ppu_addr[13];  // Nametable space is CIRAM
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~cfg.chr_write_en;

endmodule

`default_nettype wire

/* source/mapper_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_top
	import cart_types_pkg::*, cart_bus_pkg::*;
#(
	parameter int USE_SMB2J = 1  // Build the #40 port
)
(
	input  wire         m2,           // CPU clock
	input  wire         ppu_addr_in,  // Async reset, active high
	input  wire         romsel,
	input  wire         cpu_rw,
	input  wire cpu_addr_t   cpu_addr,
	input  wire cpu_data_t   cpu_data,
	output flash_addr_t cpu_addr_out,
	output logic        flash_we,
	output logic        flash_oe,
	output logic        sram_ce,
	output logic        sram_we,
	output logic        sram_oe,
	input  wire         ppu_rd,
	input  wire         ppu_wr,
	input  wire ppu_addr_t   ppu_addr,
	output chr_bank_t   ppu_addr_out,
	output logic        ppu_rd_out,
	output logic        ppu_wr_out,
	output logic        ppu_ciram_a10,
	output logic        irq           // Active low
);

	cpu_bus_t     cpu_bus;
	cart_config_t cfg;
	rom_write_t   rom_wr;
	bank_state_t  banks;
	irq_ctrl_t    irq_ctrl;

	assign cpu_bus = '{romsel, cpu_rw, cpu_addr, cpu_data};

	config_regs u_config_regs (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .cpu_bus(cpu_bus),
		.mirror_set(banks.mirror_set), .cfg(cfg), .rom_wr(rom_wr)
	);

	bank_regs #(.USE_SMB2J(USE_SMB2J)) u_bank_regs (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .rom_wr(rom_wr), .cfg(cfg),
		.banks(banks), .irq_ctrl(irq_ctrl)
	);

	irq_timer u_irq_timer (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .irq_ctrl(irq_ctrl), .irq(irq)
	);

	prg_mapper #(.USE_SMB2J(USE_SMB2J)) u_prg_mapper (
		.cpu_bus(cpu_bus), .cfg(cfg), .banks(banks), .cpu_addr_out(cpu_addr_out),
		.flash_we(flash_we), .flash_oe(flash_oe), .sram_ce(sram_ce),
		.sram_we(sram_we), .sram_oe(sram_oe)
	);

	chr_mapper u_chr_mapper (
		.cfg(cfg), .banks(banks), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr),
		.ppu_addr(ppu_addr), .ppu_addr_out(ppu_addr_out), .ppu_rd_out(ppu_rd_out),
		.ppu_wr_out(ppu_wr_out), .ppu_ciram_a10(ppu_ciram_a10)
	);

endmodule

`default_nettype wire

/* verification/mapper_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_tb;

	// Expected register contents, kept apart from the DUT
	typedef struct packed {
		logic [12:0] prg_base;
		logic [4:0]  prg_mask;
		logic [4:0]  chr_mask;
		logic [1:0]  sram_page;
		logic [4:0]  mapper;
		logic [2:0]  flags;
		logic [1:0]  mirroring;
		logic        lockout;
		logic        prg_write_en;
		logic        chr_write_en;
		logic        sram_en;
		logic [7:0]  prg_bank;
		logic [7:0]  chr_bank;
		logic [7:0]  smb2j_c000;
	} cart_model_t;

	typedef struct packed {
		logic [13:0] cpu_addr_out;
		logic        flash_we;
		logic        flash_oe;
		logic        sram_ce;
		logic        sram_we;
		logic        sram_oe;
		logic [7:0]  ppu_addr_out;
		logic        ppu_rd_out;
		logic        ppu_wr_out;
		logic        ppu_ciram_a10;
	} pin_state_t;

	localparam logic [4:0] code_uxrom = 5'd1;   // #2
	localparam logic [4:0] code_cnrom = 5'd2;   // #3
	localparam logic [4:0] code_axrom = 5'd8;   // #7
	localparam logic [4:0] code_smb2j = 5'd18;  // #40
	localparam int cycle_limit = 20000;  // About 9100 needed, two IRQ waits of 4097 each

	logic        m2;
	logic        ppu_addr_in;  // Reset
	logic        romsel;
	logic        cpu_rw;
	logic [14:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic        ppu_rd;
	logic        ppu_wr;
	logic [13:0] ppu_addr;
	logic [13:0] cpu_addr_out;
	logic        flash_we;
	logic        flash_oe;
	logic        sram_ce;
	logic        sram_we;
	logic        sram_oe;
	logic [7:0]  ppu_addr_out;
	logic        ppu_rd_out;
	logic        ppu_wr_out;
	logic        ppu_ciram_a10;
	logic        irq;

	cart_model_t model;
	logic        mirror_pending;  // AxROM mirroring lands one edge late
	logic [1:0]  mirror_next;
	pin_state_t  want;
	pin_state_t  dut_pins;
	integer      seed;
	int          errors;
	int          checks;
	int          cycles;
	int          edges;
	string       test_name;

	mapper_top u_dut (.*);

	assign dut_pins = {cpu_addr_out, flash_we, flash_oe, sram_ce, sram_we, sram_oe,
		ppu_addr_out, ppu_rd_out, ppu_wr_out, ppu_ciram_a10};

	initial
	begin
		m2 = 1'b0;
		forever #2 m2 = ~m2;  // 4 ns period
	end

	function automatic pin_state_t predict_outputs(input cart_model_t m, input logic rs,
		input logic rw, input logic [14:0] ca, input logic [13:0] pa, input logic prd,
		input logic pwr);
		pin_state_t p;
		logic       smb;
		logic       at_6000;
		logic       rom;
		logic [5:0] bank;
		logic [4:0] chr_hi;
		smb = (m.mapper == code_smb2j) && (m.flags == 3'b000);
		at_6000 = rs && (ca[14:13] == 2'b11);
		rom = !rs || (at_6000 && smb);
		if (m.mapper[3])
			bank = {m.prg_bank[3:0], ca[14:13]};  // 32K switch
		else if (ca[14])
			bank = {5'h1f, ca[13]};  // Last 16K fixed
		else
			bank = {m.prg_bank[4:0], ca[13]};
		if (smb)
		begin
			case ({rs, ca[14:13]})
				3'b111: bank = 6'd6;
				3'b000: bank = 6'd4;
				3'b001: bank = 6'd5;
				3'b010: bank = m.smb2j_c000[5:0];
				3'b011: bank = 6'd7;
				default: ;
			endcase
		end
		p.cpu_addr_out = rom ? {m.prg_base | {8'h00, bank[5:1] & ~m.prg_mask}, bank[0]}
			: {12'h000, m.sram_page};
		p.flash_we = !(!rw && !rs && m.prg_write_en);
		p.flash_oe = !(rw && rom);
		p.sram_ce = !(at_6000 && m.sram_en && !smb);
		p.sram_we = rw;
		p.sram_oe = !rw;
		chr_hi = smb ? 5'h00 : m.chr_bank[4:0];  // #40 CHR is one fixed 8K
		p.ppu_addr_out = {chr_hi & ~m.chr_mask, pa[12:10]};
		p.ppu_rd_out = prd || pa[13];
		p.ppu_wr_out = pwr || pa[13] || !m.chr_write_en;
		case (m.mirroring)
			2'd0: p.ppu_ciram_a10 = pa[10];
			2'd1: p.ppu_ciram_a10 = pa[11];
			2'd2: p.ppu_ciram_a10 = 1'b0;
			default: p.ppu_ciram_a10 = 1'b1;
		endcase
		return p;
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual)
		begin
			errors = errors + 1;
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	always @(negedge m2)  // Outputs settled half a cycle after the drive edge
	begin
		if (!ppu_addr_in)
		begin
			want = predict_outputs(model, romsel, cpu_rw, cpu_addr, ppu_addr, ppu_rd, ppu_wr);
			compare_value("outputs", 32'(want), 32'(dut_pins));
		end
	end

	function automatic logic [14:0] cfg_addr(input logic [2:0] idx);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {3'b101, rnd[8:0], idx};  // Any mirror of $5xx0-$5xx7
	endfunction

	function automatic logic [14:0] rom_addr(input logic [1:0] region);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {region, rnd[12:0]};
	endfunction

	task automatic apply_write(input logic rs, input logic [14:0] addr, input logic [7:0] data);
		if (rs && addr[14:12] == 3'b101 && !model.lockout)
		begin
			case (addr[2:0])
				3'd0: model.prg_base[12:8] = data[4:0];
				3'd1: model.prg_base[7:0] = data;
				3'd2: model.prg_mask = data[4:0];
				3'd4: model.chr_mask = data[4:0];
				3'd5: model.sram_page = data[1:0];
				3'd6: {model.flags, model.mapper} = data;
				3'd7:
				begin
					model.lockout = data[7];
					model.mirroring = data[4:3];
					{model.prg_write_en, model.chr_write_en, model.sram_en} = data[2:0];
				end
				default: ;
			endcase
		end
		else if (!rs)
		begin
			case (model.mapper)
				code_uxrom: model.prg_bank = data;
				code_cnrom: model.chr_bank = data;
				code_axrom:
				begin
					model.prg_bank = {3'b000, data[4:0]};
					mirror_pending = 1'b1;
					mirror_next = {1'b1, data[4]};  // Single-screen A or B
				end
				code_smb2j:
				begin
					if (model.flags == 3'b000 && addr[14:13] == 2'b11)
						model.smb2j_c000 = data;
				end
				default: ;
			endcase
		end
	endtask

	task automatic cpu_write(input logic rs, input logic [14:0] addr, input logic [7:0] data);
		@(posedge m2);
		romsel <= rs;
		cpu_rw <= 1'b0;
		cpu_addr <= addr;
		cpu_data <= data;
		@(posedge m2);  // Write taken here
		cpu_rw <= 1'b1;  // Read cycle follows
		apply_write(rs, addr, data);
		if (mirror_pending)
		begin
			@(posedge m2);
			model.mirroring = mirror_next;
			mirror_pending = 1'b0;
		end
	endtask

	// Back-to-back write cycles as in a read-modify-write instruction
	task automatic write_twice(input logic rs1, input logic [14:0] a1, input logic [7:0] d1,
		input logic rs2, input logic [14:0] a2, input logic [7:0] d2);
		@(posedge m2);
		romsel <= rs1;
		cpu_rw <= 1'b0;
		cpu_addr <= a1;
		cpu_data <= d1;
		@(posedge m2);
		romsel <= rs2;
		cpu_addr <= a2;
		cpu_data <= d2;
		apply_write(rs1, a1, d1);  // Only the first one counts
		@(posedge m2);
		cpu_rw <= 1'b1;
	endtask

	task automatic cfg_write(input logic [2:0] idx, input logic [7:0] data);
		cpu_write(1'b1, cfg_addr(idx), data);
	endtask

	task automatic drive_random_ppu();
		logic [31:0] rnd;
		rnd = $random(seed);
		ppu_addr <= rnd[13:0];
		ppu_rd <= rnd[14];
		ppu_wr <= rnd[15];
	endtask

	task automatic random_reads(input int count);
		logic [31:0] rnd;
		repeat (count)
		begin
			@(posedge m2);
			rnd = $random(seed);
			romsel <= rnd[31];
			cpu_rw <= 1'b1;
			cpu_addr <= rnd[14:0];
			drive_random_ppu();
		end
	endtask

	// ROM writes, or SRAM writes at $6000-$7FFF
	task automatic random_writes(input int count);
		logic [31:0] rnd;
		repeat (count)
		begin
			rnd = $random(seed);
			drive_random_ppu();
			cpu_write(rnd[31], rnd[31] ? rom_addr(2'b11) : rom_addr(rnd[1:0]), rnd[23:16]);
		end
	endtask

	task automatic bank_round(input logic [4:0] code);
		cfg_write(3'd6, {3'b000, code});
		repeat (4)
		begin
			cpu_write(1'b0, rom_addr(2'($random(seed))), 8'($random(seed)));
			random_reads(20);
		end
	endtask

	task automatic reset_dut();
		@(posedge m2);
		ppu_addr_in <= 1'b1;
		cpu_rw <= 1'b1;
		repeat (5) @(posedge m2);
		ppu_addr_in <= 1'b0;
		model = '0;
		mirror_pending = 1'b0;
	endtask

	// Counts edges until irq falls, gives up after 5000
	task automatic wait_irq_low(output int count);
		count = 0;
		while (irq !== 1'b0 && count < 5000)
		begin
			@(posedge m2);
			count = count + 1;
			@(negedge m2);
		end
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge m2);
			cycles = cycles + 1;
		end
		$display("Timeout: run stopped after %0d cycles in test %s", cycles, test_name);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		seed = 32'h20ed;
		ppu_addr_in = 1'b1;
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		ppu_rd = 1'b1;
		ppu_wr = 1'b1;
		ppu_addr = '0;
		model = '0;
		mirror_pending = 1'b0;
		mirror_next = 2'b00;
		errors = 0;
		checks = 0;
		test_name = "reset";
		reset_dut();
		@(negedge m2);
		compare_value("irq", 32'd1, 32'(irq));

		test_name = "config_window";
		cfg_write(3'd0, 8'($random(seed)));
		cfg_write(3'd1, 8'($random(seed)));
		cfg_write(3'd2, 8'($random(seed)));
		cfg_write(3'd4, 8'($random(seed)));
		cfg_write(3'd5, 8'($random(seed)));
		cfg_write(3'd6, {3'b000, code_uxrom});
		cfg_write(3'd7, 8'h01);  // SRAM on
		cpu_write(1'b0, rom_addr(2'b01), 8'h06);
		random_reads(200);

		test_name = "bank_switching";
		cfg_write(3'd7, 8'h0b);  // Horizontal, CHR RAM writable, SRAM on
		bank_round(code_uxrom);
		bank_round(code_cnrom);
		bank_round(code_axrom);

		test_name = "write_strobes";
		cfg_write(3'd6, 8'h00);  // No mapper, ROM writes touch no bank
		cfg_write(3'd7, 8'h07);
		random_writes(24);
		cfg_write(3'd7, 8'h01);
		random_writes(24);

		test_name = "write_guard";
		cfg_write(3'd6, {3'b000, code_uxrom});
		write_twice(1'b0, rom_addr(2'b00), 8'h03, 1'b0, rom_addr(2'b01), 8'h05);
		write_twice(1'b1, cfg_addr(3'd2), 8'h00, 1'b1, cfg_addr(3'd2), 8'h1f);
		random_reads(40);

		test_name = "lockout";
		cfg_write(3'd7, 8'h87);  // Lock with all enables on
		cfg_write(3'd2, 8'h1f);
		cfg_write(3'd6, {3'b000, code_axrom});
		cfg_write(3'd7, 8'h10);
		cpu_write(1'b0, rom_addr(2'b10), 8'h09);  // Mapper writes still pass
		random_reads(60);

		test_name = "smb2j";
		reset_dut();
		cfg_write(3'd1, 8'($random(seed)));
		cfg_write(3'd6, {3'b000, code_smb2j});
		cfg_write(3'd7, 8'h01);
		cpu_write(1'b0, rom_addr(2'b11), 8'($random(seed)));  // $E000, bank at $C000
		random_reads(100);
		cpu_write(1'b0, rom_addr(2'b01), 8'h00);  // $A000 starts the timer
		wait_irq_low(edges);
		if (irq !== 1'b0)
		begin
			errors = errors + 1;
			$display("irq never went low after the timer start write");
		end
		else
			compare_value("irq delay", 32'd4097, 32'(edges));
		cpu_write(1'b0, rom_addr(2'b00), 8'h00);  // $8000 stops it
		@(posedge m2);
		@(negedge m2);
		compare_value("irq after stop", 32'd1, 32'(irq));
		cpu_write(1'b0, rom_addr(2'b01), 8'h00);  // Timer runs again
		wait_irq_low(edges);
		if (irq !== 1'b0)
		begin
			errors = errors + 1;
			$display("irq never went low after the second timer start write");
		end
		reset_dut();  // Taken while irq is low
		@(negedge m2);
		compare_value("irq after reset", 32'd1, 32'(irq));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/cart_types_pkg.sv
source/cart_bus_pkg.sv
source/config_regs.sv
source/bank_regs.sv
source/irq_timer.sv
source/prg_mapper.sv
source/chr_mapper.sv
source/mapper_top.sv
verification/mapper_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module mapper_tb \
	-f sim.f -o mapper_sim &&
./obj_dir/mapper_sim | tee /dev/stderr | grep -q "Simulation passed" ||
exit 1
